/* logic/noc_alloc_pkg.sv */
package noc_alloc_pkg;

    // router geometry
    localparam int num_ports = 5;
    localparam int num_vcs   = 4;

    // a port never routes back to itself
    localparam int num_dests = num_ports - 1;

    // one bit per virtual channel
    // used for one-hot vc numbers and for vc masks
    typedef logic [num_vcs-1:0] vc_vec_t;

    // one-hot destination, relative to the sending port
    // for port i: bit k is port k below i, port k+1 otherwise
    typedef logic [num_dests-1:0] dest_vec_t;

    // request seen from one input vc
    typedef struct packed {
        // flit waiting in this vc
        logic      request;
        // packet already owns an output vc
        logic      ovc_assigned;
        // owned output vc still has a free slot
        logic      ovc_not_full;
        // route computed for the head flit
        dest_vec_t dest_port;
        // free output vcs at the destination port
        vc_vec_t   ovc_mask;
    } ivc_req_t;

    // all vcs of one input port
    typedef ivc_req_t [num_vcs-1:0] port_req_t;

    // allocation result for one input port
    typedef struct packed {
        // input vc that won the crossbar
        vc_vec_t   sw_ivc;
        // same vc, only when a new output vc comes with it
        vc_vec_t   ovc_ivc;
        // candidate output vc of the winner
        vc_vec_t   granted_ovc;
        // granted destination, zero on a loss
        dest_vec_t dest_port;
    } port_grant_t;

endpackage

/* logic/rr_arbiter.sv */
module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [width-1:0] request,
    input  logic             priority_en,
    output logic [width-1:0] grant
);

    // one-hot position with the highest priority
    logic [width-1:0]   pointer;
    logic [width-1:0]   next_pointer;

    // request vector repeated twice so the search can wrap
    logic [2*width-1:0] double_request;
    logic [2*width-1:0] double_grant;

    assign double_request = {request, request};

    // subtracting the pointer borrows out of the first set bit at or above it
    // masking with the inverted difference keeps only that bit
    assign double_grant = double_request & ~(double_request - {{width{1'b0}}, pointer});

    // fold the upper copy back onto the lower one
    assign grant = double_grant[width-1:0] | double_grant[2*width-1:width];

    // winner drops to lowest priority, its neighbour above gets the top
    assign next_pointer = {grant[width-2:0], grant[width-1]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // bit 0 first after reset
            pointer <= {{(width-1){1'b0}}, 1'b1};
        end else if (priority_en && |grant) begin
            pointer <= next_pointer;
        end
    end

endmodule

/* logic/vc_request_stage.sv */
module vc_request_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  noc_alloc_pkg::port_req_t port_req [noc_alloc_pkg::num_ports],
    output noc_alloc_pkg::vc_vec_t  ivc_request [noc_alloc_pkg::num_ports],
    output noc_alloc_pkg::vc_vec_t  candidate_ovc [noc_alloc_pkg::num_ports][noc_alloc_pkg::num_vcs]
);

    import noc_alloc_pkg::*;

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        for (genvar v = 0; v < num_vcs; v++) begin : g_vc

            ivc_req_t req;

            // assigned vc whose output vc still has room
            logic     assigned_ok;

            // unassigned vc with at least one free candidate
            logic     unassigned_ok;

            // candidates offered to this vc's own arbiter
            vc_vec_t  cand_request;

            assign req = port_req[p][v];

            assign assigned_ok   = req.ovc_assigned & req.ovc_not_full;
            assign unassigned_ok = ~req.ovc_assigned & (|req.ovc_mask);

            // back-pressure removes the request entirely
            // so no arbiter downstream sees it or rotates on it
            assign ivc_request[p][v] = req.request & (assigned_ok | unassigned_ok);

            // mask of an assigned vc is stale, keep it out
            assign cand_request = req.ovc_assigned ? '0 : req.ovc_mask;

            // one candidate output vc per input vc
            // rotates on every nonzero pick
            rr_arbiter #(
                .width (noc_alloc_pkg::num_vcs)
            ) u_cand_arb (
                .clk         (clk),
                .arst_n      (arst_n),
                .request     (cand_request),
                .priority_en (1'b1),
                .grant       (candidate_ovc[p][v])
            );

        end
    end

endmodule

/* logic/nonspec_sw_alloc.sv */
module nonspec_sw_alloc (
    input  logic                     clk,
    input  logic                     arst_n,
    input  noc_alloc_pkg::vc_vec_t   ivc_request [noc_alloc_pkg::num_ports],
    input  noc_alloc_pkg::dest_vec_t dest_port [noc_alloc_pkg::num_ports][noc_alloc_pkg::num_vcs],
    output noc_alloc_pkg::vc_vec_t   first_winner [noc_alloc_pkg::num_ports],
    output noc_alloc_pkg::dest_vec_t granted_dest [noc_alloc_pkg::num_ports]
);

    import noc_alloc_pkg::*;

    // destination of each input port's first-level winner
    dest_vec_t winner_dest [num_ports];

    // second level, indexed by output port
    // bit k names an input port with the same relative rule
    dest_vec_t out_request [num_ports];
    dest_vec_t out_grant [num_ports];

    // one-hot mux of the per-vc routes
    function automatic dest_vec_t select_dest(
        input vc_vec_t   sel,
        input dest_vec_t ivc_dest [num_vcs]
    );
        dest_vec_t result;
        result = '0;
        for (int v = 0; v < num_vcs; v++) begin
            if (sel[v]) begin
                result = result | ivc_dest[v];
            end
        end
        return result;
    endfunction

    for (genvar i = 0; i < num_ports; i++) begin : g_in_port

        // port pointer holds still unless this port wins an output
        logic port_granted;

        assign port_granted = |granted_dest[i];

        // first level, picks one vc per input port
        rr_arbiter #(
            .width (noc_alloc_pkg::num_vcs)
        ) u_in_arb (
            .clk         (clk),
            .arst_n      (arst_n),
            .request     (ivc_request[i]),
            .priority_en (port_granted),
            .grant       (first_winner[i])
        );

        assign winner_dest[i] = select_dest(first_winner[i], dest_port[i]);

    end

    for (genvar o = 0; o < num_ports; o++) begin : g_out_port

        // crossbar between relative numbering on both sides
        for (genvar j = 0; j < num_ports; j++) begin : g_route
            if (j < o) begin : g_below
                // output o seen from input j is relative bit o-1
                assign out_request[o][j]  = winner_dest[j][o-1];
                assign granted_dest[j][o-1] = out_grant[o][j];
            end else if (j > o) begin : g_above
                // input j seen from output o is relative bit j-1
                assign out_request[o][j-1] = winner_dest[j][o];
                assign granted_dest[j][o]  = out_grant[o][j-1];
            end
            // j == o never routes, the port has no path to itself
        end

        // second level, picks one input port per output
        // rotates every time it grants
        rr_arbiter #(
            .width (noc_alloc_pkg::num_dests)
        ) u_out_arb (
            .clk         (clk),
            .arst_n      (arst_n),
            .request     (out_request[o]),
            .priority_en (1'b1),
            .grant       (out_grant[o])
        );

    end

endmodule

/* logic/ovc_grant_map.sv */
module ovc_grant_map (
    input  noc_alloc_pkg::vc_vec_t      first_winner [noc_alloc_pkg::num_ports],
    input  noc_alloc_pkg::dest_vec_t    granted_dest [noc_alloc_pkg::num_ports],
    input  noc_alloc_pkg::vc_vec_t      candidate_ovc [noc_alloc_pkg::num_ports][noc_alloc_pkg::num_vcs],
    input  noc_alloc_pkg::port_req_t    port_req [noc_alloc_pkg::num_ports],
    output noc_alloc_pkg::port_grant_t  port_grant [noc_alloc_pkg::num_ports],
    output noc_alloc_pkg::vc_vec_t      ovc_allocated [noc_alloc_pkg::num_ports]
);

    import noc_alloc_pkg::*;

    // output vc newly taken by each input port, zero if none
    vc_vec_t new_ovc [num_ports];

    always_comb begin
        vc_vec_t winner_cand;
        logic    winner_assigned;
        logic    port_granted;
        logic    gets_ovc;
        for (int p = 0; p < num_ports; p++) begin
            winner_cand     = '0;
            winner_assigned = 1'b0;

            // pick the winner's candidate and its assignment state
            for (int v = 0; v < num_vcs; v++) begin
                if (first_winner[p][v]) begin
                    winner_cand     = winner_cand | candidate_ovc[p][v];
                    winner_assigned = winner_assigned | port_req[p][v].ovc_assigned;
                end
            end

            port_granted = |granted_dest[p];

            // assigned winners keep their old output vc
            gets_ovc = port_granted & (|winner_cand) & ~winner_assigned;

            port_grant[p].sw_ivc      = port_granted ? first_winner[p] : '0;
            port_grant[p].ovc_ivc     = gets_ovc ? first_winner[p] : '0;
            port_grant[p].granted_ovc = port_granted ? winner_cand : '0;
            port_grant[p].dest_port   = granted_dest[p];

            new_ovc[p] = gets_ovc ? winner_cand : '0;
        end
    end

    // scatter each new output vc to its absolute output port
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            ovc_allocated[o] = '0;
            for (int j = 0; j < num_ports; j++) begin
                if (j < o) begin
                    // output o is relative bit o-1 for input j
                    if (granted_dest[j][o-1]) begin
                        ovc_allocated[o] = ovc_allocated[o] | new_ovc[j];
                    end
                end else if (j > o) begin
                    if (granted_dest[j][o]) begin
                        ovc_allocated[o] = ovc_allocated[o] | new_ovc[j];
                    end
                end
            end
        end
    end

endmodule

/* logic/comb_nonspec_allocator.sv */
module comb_nonspec_allocator (
    input  logic                       clk,
    input  logic                       arst_n,
    input  noc_alloc_pkg::port_req_t   port_req [noc_alloc_pkg::num_ports],
    output noc_alloc_pkg::port_grant_t port_grant [noc_alloc_pkg::num_ports],
    output noc_alloc_pkg::vc_vec_t     ovc_allocated [noc_alloc_pkg::num_ports]
);

    import noc_alloc_pkg::*;

    // qualified per-vc requests, one vector per input port
    vc_vec_t   ivc_request [num_ports];

    // candidate output vc picked for each input vc
    vc_vec_t   candidate_ovc [num_ports][num_vcs];

    // per-vc routes unpacked from the request structs
    dest_vec_t ivc_dest [num_ports][num_vcs];

    // switch allocation results
    vc_vec_t   first_winner [num_ports];
    dest_vec_t granted_dest [num_ports];

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        for (genvar v = 0; v < num_vcs; v++) begin : g_vc
            assign ivc_dest[p][v] = port_req[p][v].dest_port;
        end
    end

    // request qualification and candidate vc selection
    vc_request_stage u_vc_request_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .port_req      (port_req),
        .ivc_request   (ivc_request),
        .candidate_ovc (candidate_ovc)
    );

    // input port then output port arbitration
    nonspec_sw_alloc u_nonspec_sw_alloc (
        .clk          (clk),
        .arst_n       (arst_n),
        .ivc_request  (ivc_request),
        .dest_port    (ivc_dest),
        .first_winner (first_winner),
        .granted_dest (granted_dest)
    );

    // switch grants become vc grants
    ovc_grant_map u_ovc_grant_map (
        .first_winner  (first_winner),
        .granted_dest  (granted_dest),
        .candidate_ovc (candidate_ovc),
        .port_req      (port_req),
        .port_grant    (port_grant),
        .ovc_allocated (ovc_allocated)
    );

endmodule

/* testbench/comb_nonspec_allocator_properties.sv */
module comb_nonspec_allocator_properties (
    input logic                       clk,
    input logic                       arst_n,
    input noc_alloc_pkg::port_grant_t port_grant [noc_alloc_pkg::num_ports],
    input noc_alloc_pkg::vc_vec_t     ovc_allocated [noc_alloc_pkg::num_ports]
);

    import noc_alloc_pkg::*;

    // set when two input ports take a new vc at one output
    logic [num_ports-1:0] shared_output;

    always_comb begin
        int takers;
        int rel;
        for (int o = 0; o < num_ports; o++) begin
            takers = 0;
            for (int j = 0; j < num_ports; j++) begin
                if (j != o) begin
                    // output o in the relative numbering of input j
                    rel = (o < j) ? o : o - 1;
                    if (port_grant[j].dest_port[rel] && (|port_grant[j].ovc_ivc)) begin
                        takers++;
                    end
                end
            end
            shared_output[o] = (takers > 1);
        end
    end

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        // one crossbar winner per input port at most
        a_sw_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(port_grant[p].sw_ivc))
            else $error("sw_ivc of input port %0d has several bits set", p);

        // new output vc only goes to the switch winner
        a_ovc_subset: assert property (@(posedge clk) disable iff (!arst_n)
            (port_grant[p].ovc_ivc & ~port_grant[p].sw_ivc) == '0)
            else $error("ovc_ivc of input port %0d outside sw_ivc", p);

        a_out_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
            !shared_output[p] && $onehot0(ovc_allocated[p]))
            else $error("output port %0d allocated to two input ports", p);
    end

endmodule

bind comb_nonspec_allocator comb_nonspec_allocator_properties u_properties (
    .clk           (clk),
    .arst_n        (arst_n),
    .port_grant    (port_grant),
    .ovc_allocated (ovc_allocated)
);

/* testbench/tb_comb_nonspec_allocator.sv */
module tb_comb_nonspec_allocator;

    import noc_alloc_pkg::*;

    localparam int clk_period    = 20;
    localparam int half_period   = clk_period / 2;
    localparam int reset_cycles  = 4;
    localparam int random_cycles = 200;
    // reset, one lead-in per test, directed cycles, random run
    localparam int test_cycles   = reset_cycles + 6 + 22 + random_cycles;
    localparam int margin_cycles = 50;

    // mirror of every arbiter pointer in the dut
    typedef struct packed {
        vc_vec_t   [num_ports*num_vcs-1:0] cand_ptr;
        vc_vec_t   [num_ports-1:0]         in_ptr;
        dest_vec_t [num_ports-1:0]         out_ptr;
    } model_state_t;

    // expected outputs, plus the arbiter grants that move pointers
    typedef struct packed {
        port_grant_t [num_ports-1:0]         grant;
        vc_vec_t     [num_ports-1:0]         alloc;
        vc_vec_t     [num_ports*num_vcs-1:0] cand_win;
        vc_vec_t     [num_ports-1:0]         first_win;
        dest_vec_t   [num_ports-1:0]         out_win;
    } model_result_t;

    logic          clk;
    logic          arst_n;
    port_req_t     port_req [num_ports];
    port_grant_t   port_grant [num_ports];
    vc_vec_t       ovc_allocated [num_ports];

    model_state_t  state;
    model_result_t expected;
    int            seed;
    int            error_count;
    int            check_count;
    int            test_count;
    int            errors_at_start;

    comb_nonspec_allocator u_comb_nonspec_allocator (
        .clk           (clk),
        .arst_n        (arst_n),
        .port_req      (port_req),
        .port_grant    (port_grant),
        .ovc_allocated (ovc_allocated)
    );

    always #(half_period) clk = ~clk;

    // first request at or after the pointer, wrapping
    function automatic logic [7:0] rr_pick(input logic [7:0] req, input logic [7:0] ptr,
                                           input int width);
        int         start;
        int         idx;
        logic [7:0] result;
        start  = 0;
        result = '0;
        for (int k = 0; k < width; k++) begin
            if (ptr[k]) begin
                start = k;
            end
        end
        for (int k = 0; k < width; k++) begin
            idx = (start + k) % width;
            if (result == '0 && req[idx]) begin
                result[idx] = 1'b1;
            end
        end
        return result;
    endfunction

    // pointer lands one above the winner
    function automatic logic [7:0] ptr_after(input logic [7:0] winner, input int width);
        logic [7:0] result;
        result = '0;
        for (int k = 0; k < width; k++) begin
            if (winner[k]) begin
                result[(k + 1) % width] = 1'b1;
            end
        end
        return result;
    endfunction

    // port other as numbered from port self, which skips itself
    function automatic int rel_index(input int self, input int other);
        return (other < self) ? other : other - 1;
    endfunction

    function automatic model_state_t reset_state();
        model_state_t st;
        st = '0;
        for (int i = 0; i < num_ports * num_vcs; i++) begin
            st.cand_ptr[i][0] = 1'b1;
        end
        for (int p = 0; p < num_ports; p++) begin
            st.in_ptr[p][0]  = 1'b1;
            st.out_ptr[p][0] = 1'b1;
        end
        return st;
    endfunction

    function automatic model_result_t reference_alloc(input port_req_t req [num_ports],
                                                      input model_state_t st);
        model_result_t res;
        vc_vec_t       qual [num_ports];
        dest_vec_t     win_dest [num_ports];
        dest_vec_t     out_req;
        vc_vec_t       cand_req;
        vc_vec_t       cand;
        logic          assigned;
        int            i;
        res = '0;
        for (int p = 0; p < num_ports; p++) begin
            win_dest[p] = '0;
            for (int v = 0; v < num_vcs; v++) begin
                i = p * num_vcs + v;
                // full output vc or empty mask drops the request
                qual[p][v] = req[p][v].request &
                    ((req[p][v].ovc_assigned & req[p][v].ovc_not_full) |
                     (~req[p][v].ovc_assigned & (|req[p][v].ovc_mask)));
                cand_req = req[p][v].ovc_assigned ? '0 : req[p][v].ovc_mask;
                res.cand_win[i] = vc_vec_t'(rr_pick(8'(cand_req), 8'(st.cand_ptr[i]), num_vcs));
            end
            res.first_win[p] = vc_vec_t'(rr_pick(8'(qual[p]), 8'(st.in_ptr[p]), num_vcs));
            for (int v = 0; v < num_vcs; v++) begin
                if (res.first_win[p][v]) begin
                    win_dest[p] = req[p][v].dest_port;
                end
            end
        end
        // one input port per output, requests in relative order
        for (int o = 0; o < num_ports; o++) begin
            out_req = '0;
            for (int j = 0; j < num_ports; j++) begin
                if (j != o) begin
                    out_req[rel_index(o, j)] = win_dest[j][rel_index(j, o)];
                end
            end
            res.out_win[o] = dest_vec_t'(rr_pick(8'(out_req), 8'(st.out_ptr[o]), num_dests));
            for (int j = 0; j < num_ports; j++) begin
                if (j != o && res.out_win[o][rel_index(o, j)]) begin
                    res.grant[j].dest_port[rel_index(j, o)] = 1'b1;
                end
            end
        end
        for (int p = 0; p < num_ports; p++) begin
            cand     = '0;
            assigned = 1'b0;
            for (int v = 0; v < num_vcs; v++) begin
                if (res.first_win[p][v]) begin
                    cand     = res.cand_win[p * num_vcs + v];
                    assigned = req[p][v].ovc_assigned;
                end
            end
            if (|res.grant[p].dest_port) begin
                res.grant[p].sw_ivc      = res.first_win[p];
                res.grant[p].granted_ovc = cand;
                // a packet with an output vc keeps it
                if (!assigned && cand != '0) begin
                    res.grant[p].ovc_ivc = res.first_win[p];
                    for (int o = 0; o < num_ports; o++) begin
                        if (o != p && res.grant[p].dest_port[rel_index(p, o)]) begin
                            res.alloc[o] = res.alloc[o] | cand;
                        end
                    end
                end
            end
        end
        return res;
    endfunction

    function automatic model_state_t advance_state(input model_state_t st,
                                                   input model_result_t res);
        model_state_t nxt;
        nxt = st;
        for (int i = 0; i < num_ports * num_vcs; i++) begin
            if (|res.cand_win[i]) begin
                nxt.cand_ptr[i] = vc_vec_t'(ptr_after(8'(res.cand_win[i]), num_vcs));
            end
        end
        for (int p = 0; p < num_ports; p++) begin
            // input port pointer moves only on a won output
            if ((|res.grant[p].dest_port) && (|res.first_win[p])) begin
                nxt.in_ptr[p] = vc_vec_t'(ptr_after(8'(res.first_win[p]), num_vcs));
            end
            if (|res.out_win[p]) begin
                nxt.out_ptr[p] = dest_vec_t'(ptr_after(8'(res.out_win[p]), num_dests));
            end
        end
        return nxt;
    endfunction

    // compare just before the rising edge, then step the model
    always begin
        @(negedge clk);
        #(half_period - 1);
        if (arst_n) begin
            expected = reference_alloc(port_req, state);
            for (int p = 0; p < num_ports; p++) begin
                check_count += 2;
                assert (port_grant[p] == expected.grant[p]) else begin
                    $display("error at %0t: port_grant[%0d] expected %h got %h",
                             $time, p, expected.grant[p], port_grant[p]);
                    error_count++;
                end
                assert (ovc_allocated[p] == expected.alloc[p]) else begin
                    $display("error at %0t: ovc_allocated[%0d] expected %b got %b",
                             $time, p, expected.alloc[p], ovc_allocated[p]);
                    error_count++;
                end
            end
        end
        @(posedge clk);
        if (!arst_n) begin
            state = reset_state();
        end else begin
            state = advance_state(state, expected);
        end
    end

    task automatic clear_requests();
        for (int p = 0; p < num_ports; p++) begin
            port_req[p] = '0;
        end
    endtask

    task automatic drive_ivc(input int p, input int v, input logic assigned,
                             input logic not_full, input int dest_bit, input vc_vec_t mask);
        port_req[p][v]                     = '0;
        port_req[p][v].request             = 1'b1;
        port_req[p][v].ovc_assigned        = assigned;
        port_req[p][v].ovc_not_full        = not_full;
        port_req[p][v].dest_port[dest_bit] = 1'b1;
        port_req[p][v].ovc_mask            = mask;
    endtask

    task automatic randomize_requests();
        logic [31:0] r;
        for (int p = 0; p < num_ports; p++) begin
            for (int v = 0; v < num_vcs; v++) begin
                r = $random(seed);
                port_req[p][v].request             = r[0];
                port_req[p][v].ovc_assigned        = r[1];
                // full outputs rarer than free ones
                port_req[p][v].ovc_not_full        = r[2] | r[3];
                port_req[p][v].dest_port           = '0;
                port_req[p][v].dest_port[r[5:4]]   = 1'b1;
                port_req[p][v].ovc_mask            = r[9:6];
            end
        end
    endtask

    task automatic wait_settle();
        #(half_period - 1);
    endtask

    task automatic expect_vec(input string name, input vc_vec_t got, input vc_vec_t want);
        check_count++;
        assert (got == want) else begin
            $display("error at %0t: %s expected %b got %b", $time, name, want, got);
            error_count++;
        end
    endtask

    task automatic start_test();
        @(negedge clk);
        clear_requests();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
    endtask

    initial begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        seed            = 32'hc2a3;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        errors_at_start = 0;
        state           = reset_state();
        expected        = '0;
        clear_requests();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // port 2 vc 1 towards port 0, lowest free candidate is vc 1
        start_test();
        drive_ivc(2, 1, 1'b0, 1'b0, 0, 4'b0110);
        wait_settle();
        expect_vec("port_grant[2].granted_ovc", port_grant[2].granted_ovc, 4'b0010);
        expect_vec("ovc_allocated[0]", ovc_allocated[0], 4'b0010);
        finish_test("lone unassigned request");

        // port 3 vc 0 already owns a vc at port 4, full at first
        start_test();
        drive_ivc(3, 0, 1'b1, 1'b0, 3, 4'b0000);
        repeat (2) begin
            wait_settle();
            expect_vec("port_grant[3].sw_ivc", port_grant[3].sw_ivc, 4'b0000);
            @(negedge clk);
        end
        // vc 2 joins, a pointer left at vc 0 still favours vc 0
        port_req[3][0].ovc_not_full = 1'b1;
        drive_ivc(3, 2, 1'b1, 1'b1, 3, 4'b0000);
        wait_settle();
        expect_vec("port_grant[3].sw_ivc", port_grant[3].sw_ivc, 4'b0001);
        expect_vec("port_grant[3].ovc_ivc", port_grant[3].ovc_ivc, 4'b0000);
        finish_test("assigned request and back-pressure");

        // no free candidate at the destination
        start_test();
        drive_ivc(4, 2, 1'b0, 1'b0, 0, 4'b0000);
        repeat (3) begin
            wait_settle();
            expect_vec("port_grant[4].sw_ivc", port_grant[4].sw_ivc, 4'b0000);
            @(negedge clk);
        end
        finish_test("empty candidate mask");

        // ports 0, 1 and 2 all aim at port 4
        start_test();
        drive_ivc(0, 0, 1'b0, 1'b0, 3, 4'b1111);
        drive_ivc(1, 0, 1'b0, 1'b0, 3, 4'b1111);
        drive_ivc(2, 0, 1'b0, 1'b0, 3, 4'b1111);
        repeat (6) @(negedge clk);
        finish_test("input ports share one output");

        // port 1 vcs only rotate when port 1 beats port 0 at port 3
        start_test();
        drive_ivc(1, 0, 1'b1, 1'b1, 2, 4'b0000);
        drive_ivc(1, 1, 1'b1, 1'b1, 2, 4'b0000);
        drive_ivc(1, 2, 1'b1, 1'b1, 2, 4'b0000);
        drive_ivc(0, 3, 1'b1, 1'b1, 2, 4'b0000);
        repeat (8) @(negedge clk);
        finish_test("vc rotation on won outputs");

        start_test();
        repeat (random_cycles) begin
            @(negedge clk);
            randomize_requests();
        end
        finish_test("random traffic");

        $display("tests: %0d  checks: %0d  errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("timeout: run still going after %0d cycles", test_cycles + margin_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* comb_nonspec_allocator.f */
logic/noc_alloc_pkg.sv
logic/rr_arbiter.sv
logic/vc_request_stage.sv
logic/nonspec_sw_alloc.sv
logic/ovc_grant_map.sv
logic/comb_nonspec_allocator.sv
testbench/comb_nonspec_allocator_properties.sv
testbench/tb_comb_nonspec_allocator.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_comb_nonspec_allocator
FILELIST  ?= comb_nonspec_allocator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# an aborted run leaves the fail message in the log as well
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
